/* common/sa_consts.svh */
`ifndef SA_CONSTS_SVH
`define SA_CONSTS_SVH

// array geometry
`define SA_ROWS 4
`define SA_COLS 4

// operand and accumulator widths
`define SA_DW 8
`define SA_AW 24

// job descriptor fields
`define SA_LW 8
`define SA_SW 5

`endif

/* common/sa_ctrl_pkg.sv */
`include "sa_consts.svh"

package sa_ctrl_pkg;

  ////////////////////
  // job fields
  ////////////////////

  // beats per job where zero is not a job
  typedef logic [`SA_LW-1:0] klen_t;

  // requant right shift with 0 to 23 in use
  typedef logic [`SA_SW-1:0] shift_t;

  // descriptor handed over with start
  typedef struct packed {
    klen_t  klen;
    shift_t shift;
  } job_t;

  ////////////////////
  // controller
  ////////////////////

  // IDLE    waits for a start
  // STREAM  counts host beats
  // FLUSH   lets the wavefront reach the far corner
  // DRAIN   result block reads rows out
  typedef enum logic [1:0] {
    IDLE,
    STREAM,
    FLUSH,
    DRAIN
  } ctrl_state_e;

endpackage

/* common/sa_data_pkg.sv */
`include "sa_consts.svh"

package sa_data_pkg;

  ////////////////////
  // scalar types
  ////////////////////

  // int8 operand or requantized result
  typedef logic signed [`SA_DW-1:0] int8_t;

  // per-PE accumulator
  typedef logic signed [`SA_AW-1:0] acc_t;

  // index of one array row
  localparam int ROW_IW = $clog2(`SA_ROWS);
  typedef logic [ROW_IW-1:0] row_idx_t;

  ////////////////////
  // bundles
  ////////////////////

  // one lane of an edge vector
  typedef struct packed {
    logic  valid;
    int8_t data;
  } lane_t;

  // one drained output row
  typedef struct packed {
    row_idx_t                row;
    int8_t [`SA_COLS-1:0]    data;
  } res_row_t;

  // every accumulator of the grid in row major order
  typedef acc_t [`SA_ROWS-1:0][`SA_COLS-1:0] acc_grid_t;

endpackage

/* files.f */
+incdir+common
common/sa_data_pkg.sv
common/sa_ctrl_pkg.sv
systolic/sa_lane_skew.sv
systolic/sa_pe.sv
systolic/sa_array.sv
hw/sa_job_decode.sv
hw/sa_result_drain.sv
hw/sa_top.sv
test/sa_tb.sv

/* hw/sa_job_decode.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_job_decode
  import sa_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   start,
  input  job_t   job,
  input  logic   in_valid,
  input  logic   done,
  output logic   busy,
  output logic   acc_clear,
  output logic   beat_en,
  output logic   drain_go,
  output shift_t shift
);

  // last beat needs rows+cols-1 hops to reach the far PE
  localparam int FLUSH_CYC = `SA_ROWS + `SA_COLS - 1;
  localparam int FW = $clog2(FLUSH_CYC);

  ctrl_state_e   state_q;
  klen_t         beats_left_q;
  logic [FW-1:0] flush_cnt_q;
  logic          start_ok;

  // zero length or busy start is dropped
  assign start_ok = start && (state_q == IDLE) && (job.klen != '0);
  assign beat_en  = in_valid && (state_q == STREAM);
  assign busy     = (state_q != IDLE);

  ////////////////////
  // job FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      beats_left_q <= '0;
      flush_cnt_q  <= '0;
      acc_clear    <= 1'b0;
      drain_go     <= 1'b0;
    end else begin
      acc_clear <= start_ok;
      drain_go  <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_ok) begin
            beats_left_q <= job.klen;
            state_q      <= STREAM;
          end
        end
        STREAM: begin
          if (beat_en) begin
            beats_left_q <= beats_left_q - 1'b1;
            if (beats_left_q == klen_t'(1)) begin
              flush_cnt_q <= '0;
              state_q     <= FLUSH;
            end
          end
        end
        FLUSH: begin
          flush_cnt_q <= flush_cnt_q + 1'b1;
          if (flush_cnt_q == FW'(FLUSH_CYC - 1)) begin
            drain_go <= 1'b1;
            state_q  <= DRAIN;
          end
        end
        // drain block owns the row count
        DRAIN: begin
          if (done) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // shift held for the whole job
  always_ff @(posedge clk) begin
    if (start_ok) begin
      shift <= job.shift;
    end
  end

endmodule

/* hw/sa_result_drain.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_result_drain
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      drain_go,
  input  shift_t    shift,
  input  acc_grid_t acc_grid,
  output logic      res_valid,
  output res_row_t  res,
  output logic      done
);

  localparam row_idx_t LAST_ROW = row_idx_t'(`SA_ROWS - 1);
  localparam acc_t     SAT_HI   = acc_t'(2**(`SA_DW-1) - 1);
  localparam acc_t     SAT_LO   = acc_t'(-(2**(`SA_DW-1)));

  row_idx_t             row_q;
  logic                 active_q;
  logic                 rd_en;
  int8_t [`SA_COLS-1:0] row_data;

  // arithmetic shift then clamp to int8
  function automatic int8_t requant(input acc_t value, input shift_t sh);
    acc_t shifted;
    shifted = value >>> sh;
    if (shifted > SAT_HI) begin
      return int8_t'(SAT_HI);
    end else if (shifted < SAT_LO) begin
      return int8_t'(SAT_LO);
    end
    return int8_t'(shifted);
  endfunction

  // row 0 is read in the drain_go cycle itself
  assign rd_en = drain_go || active_q;

  always_comb begin
    for (int c = 0; c < `SA_COLS; c++) begin
      row_data[c] = requant(acc_grid[row_q][c], shift);
    end
  end

  ////////////////////
  // row sequencing
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_q     <= '0;
      active_q  <= 1'b0;
      res_valid <= 1'b0;
      done      <= 1'b0;
    end else begin
      res_valid <= rd_en;
      done      <= rd_en && (row_q == LAST_ROW);
      if (rd_en) begin
        // wraps to 0 so the next job starts at row 0
        row_q    <= (row_q == LAST_ROW) ? '0 : row_q + 1'b1;
        active_q <= (row_q != LAST_ROW);
      end
    end
  end

  // output row with its index
  always_ff @(posedge clk) begin
    if (rd_en) begin
      res.row  <= row_q;
      res.data <= row_data;
    end
  end

endmodule

/* hw/sa_top.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_top
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  job_t                   job,
  input  logic                   in_valid,
  input  int8_t [`SA_ROWS-1:0]   w_vec,
  input  int8_t [`SA_COLS-1:0]   a_vec,
  output logic                   busy,
  output logic                   res_valid,
  output res_row_t               res,
  output logic                   done
);

  logic                  acc_clear;
  logic                  beat_en;
  logic                  drain_go;
  shift_t                shift;
  lane_t [`SA_ROWS-1:0]  w_lane;
  lane_t [`SA_COLS-1:0]  a_lane;
  lane_t [`SA_ROWS-1:0]  w_skewed;
  lane_t [`SA_COLS-1:0]  a_skewed;
  acc_grid_t             acc_grid;

  ////////////////////
  // controller
  ////////////////////

  sa_job_decode dec0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .job       (job),
    .in_valid  (in_valid),
    .done      (done),
    .busy      (busy),
    .acc_clear (acc_clear),
    .beat_en   (beat_en),
    .drain_go  (drain_go),
    .shift     (shift)
  );

  // every lane of a beat shares the gated strobe
  for (genvar r = 0; r < `SA_ROWS; r++) begin : g_w_lane
    assign w_lane[r] = '{valid: beat_en, data: w_vec[r]};
  end

  for (genvar c = 0; c < `SA_COLS; c++) begin : g_a_lane
    assign a_lane[c] = '{valid: beat_en, data: a_vec[c]};
  end

  ////////////////////
  // execute
  ////////////////////

  sa_lane_skew #(.lanes(`SA_ROWS)) w_skew0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .lane_in  (w_lane),
    .lane_out (w_skewed)
  );

  sa_lane_skew #(.lanes(`SA_COLS)) a_skew0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .lane_in  (a_lane),
    .lane_out (a_skewed)
  );

  sa_array array0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_clear (acc_clear),
    .w_edge    (w_skewed),
    .a_edge    (a_skewed),
    .acc_grid  (acc_grid)
  );

  // drain and requantize
  sa_result_drain drain0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .drain_go  (drain_go),
    .shift     (shift),
    .acc_grid  (acc_grid),
    .res_valid (res_valid),
    .res       (res),
    .done      (done)
  );

endmodule

/* systolic/sa_array.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_array
  import sa_data_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   acc_clear,
  input  lane_t [`SA_ROWS-1:0]   w_edge,
  input  lane_t [`SA_COLS-1:0]   a_edge,
  output acc_grid_t              acc_grid
);

  ////////////////////
  // mesh links
  ////////////////////

  // column SA_COLS of w_link and row SA_ROWS of a_link fall off the edge
  wire lane_t w_link [`SA_ROWS][`SA_COLS+1];
  wire lane_t a_link [`SA_ROWS+1][`SA_COLS];

  // left edge takes the skewed weights
  for (genvar r = 0; r < `SA_ROWS; r++) begin : g_w_edge
    assign w_link[r][0] = w_edge[r];
  end

  // top edge takes the skewed activations
  for (genvar c = 0; c < `SA_COLS; c++) begin : g_a_edge
    assign a_link[0][c] = a_edge[c];
  end

  ////////////////////
  // PE grid
  ////////////////////

  for (genvar r = 0; r < `SA_ROWS; r++) begin : g_row
    for (genvar c = 0; c < `SA_COLS; c++) begin : g_col
      sa_pe pe0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .w_in      (w_link[r][c]),
        .a_in      (a_link[r][c]),
        .w_out     (w_link[r][c+1]),
        .a_out     (a_link[r+1][c]),
        .acc       (acc_grid[r][c])
      );
    end
  end

endmodule

/* systolic/sa_lane_skew.sv */
`timescale 1ns/1ps

module sa_lane_skew
  import sa_data_pkg::*;
#(
  parameter int lanes = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  lane_t [lanes-1:0]   lane_in,
  output lane_t [lanes-1:0]   lane_out
);

  // lane i passes through i+1 registers for the diagonal wavefront
  for (genvar i = 0; i < lanes; i++) begin : g_lane
    lane_t pipe_q [i+1];

    always_ff @(posedge clk) begin
      pipe_q[0].data <= lane_in[i].data;
      for (int s = 1; s <= i; s++) begin
        pipe_q[s].data <= pipe_q[s-1].data;
      end

      // valid bits follow the same chain
      if (!rst_n) begin
        for (int s = 0; s <= i; s++) begin
          pipe_q[s].valid <= 1'b0;
        end
      end else begin
        pipe_q[0].valid <= lane_in[i].valid;
        for (int s = 1; s <= i; s++) begin
          pipe_q[s].valid <= pipe_q[s-1].valid;
        end
      end
    end

    assign lane_out[i] = pipe_q[i];
  end

endmodule

/* systolic/sa_pe.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_pe
  import sa_data_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  acc_clear,
  input  lane_t w_in,
  input  lane_t a_in,
  output lane_t w_out,
  output lane_t a_out,
  output acc_t  acc
);

  logic signed [2*`SA_DW-1:0] prod;
  logic                       mac_en;

  // both operands of the same beat arrive together
  assign mac_en = w_in.valid && a_in.valid;
  assign prod   = w_in.data * a_in.data;

  // one hop right for weights, one hop down for activations
  always_ff @(posedge clk) begin
    w_out.data <= w_in.data;
    a_out.data <= a_in.data;
    if (!rst_n) begin
      w_out.valid <= 1'b0;
      a_out.valid <= 1'b0;
    end else begin
      w_out.valid <= w_in.valid;
      a_out.valid <= a_in.valid;
    end
  end

  // clear wins over a MAC in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
    end else if (acc_clear) begin
      acc <= '0;
    end else if (mac_en) begin
      acc <= acc + acc_t'(prod);
    end
  end

endmodule

/* test/sa_tb.sv */
`timescale 1ns/1ps
`include "sa_consts.svh"

module sa_tb
  import sa_data_pkg::*;
  import sa_ctrl_pkg::*;
();

  localparam int RESET_CYC  = 4;
  localparam int MAX_K      = 256;
  localparam int IDLE_CYC   = 8;
  localparam int MODE_SMALL = 0;
  localparam int MODE_FULL  = 1;
  localparam int MODE_LARGE = 2;

  // worst case cycles of one job including gaps, flush and drain
  function automatic int job_cycles(input int klen, input int max_gap);
    return klen + 2 * klen * max_gap + 20;
  endfunction

  localparam int BUDGET_CYC = RESET_CYC + 2 * IDLE_CYC + job_cycles(5, 0)
                              + 3 * job_cycles(255, 0) + job_cycles(20, 3)
                              + 2 * job_cycles(12, 0);

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  job_t                 job;
  logic                 in_valid;
  int8_t [`SA_ROWS-1:0] w_vec;
  int8_t [`SA_COLS-1:0] a_vec;
  logic                 busy;
  logic                 res_valid;
  res_row_t             res;
  logic                 done;

  integer               seed = 32'h4842_0423;
  int                   err_cnt = 0;
  int                   pass_cnt = 0;
  int                   fail_cnt = 0;
  int                   total_rows = 0;
  bit                   seen_start = 1'b0;
  string                cur_test = "reset";

  int8_t [`SA_ROWS-1:0] w_mem [MAX_K];
  int8_t [`SA_COLS-1:0] a_mem [MAX_K];
  int8_t [`SA_COLS-1:0] exp_rows [`SA_ROWS];

  sa_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .job       (job),
    .in_valid  (in_valid),
    .w_vec     (w_vec),
    .a_vec     (a_vec),
    .busy      (busy),
    .res_valid (res_valid),
    .res       (res),
    .done      (done)
  );

  always #10 clk = ~clk;

  // rows seen so far over all jobs
  always @(posedge clk) begin
    if (rst_n && res_valid) begin
      total_rows <= total_rows + 1;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
      !seen_start |-> (!busy && !res_valid && !done))
    else begin
      err_cnt++;
      $display("%s: busy, res_valid or done went high before the first start", cur_test);
    end

  a_row_value: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (res.data == exp_rows[res.row]))
    else begin
      err_cnt++;
      $display("mismatch %s row %0d expected %h actual %h", cur_test, $sampled(res.row),
               exp_rows[$sampled(res.row)], $sampled(res.data));
    end

  a_row_order: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (res.row == row_idx_t'(total_rows % `SA_ROWS)))
    else begin
      err_cnt++;
      $display("mismatch %s row index expected %0d actual %0d", cur_test,
               $sampled(total_rows) % `SA_ROWS, $sampled(res.row));
    end

  a_done_on_last: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> (res_valid && res.row == row_idx_t'(`SA_ROWS - 1)))
    else begin
      err_cnt++;
      $display("%s: done came without the last result row", cur_test);
    end

  a_last_has_done: assert property (@(posedge clk) disable iff (!rst_n)
      (res_valid && res.row == row_idx_t'(`SA_ROWS - 1)) |-> done)
    else begin
      err_cnt++;
      $display("%s: last result row came without done", cur_test);
    end

  a_res_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> busy)
    else begin
      err_cnt++;
      $display("%s: res_valid came while busy was low", cur_test);
    end

  a_start_taken: assert property (@(posedge clk) disable iff (!rst_n)
      (start && !busy && job.klen != '0) |=> busy)
    else begin
      err_cnt++;
      $display("%s: busy did not rise after a valid start", cur_test);
    end

  a_zero_len_dropped: assert property (@(posedge clk) disable iff (!rst_n)
      (start && !busy && job.klen == '0) |=> !busy)
    else begin
      err_cnt++;
      $display("%s: busy rose on a start with zero length", cur_test);
    end

  ////////////////////
  // stimulus helpers
  ////////////////////

  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic gen_operands(input int mode, input int klen);
    int mag;
    for (int k = 0; k < klen; k++) begin
      for (int r = 0; r < `SA_ROWS; r++) begin
        mag = 64 + ({$random(seed)} % 64);
        case (mode)
          MODE_SMALL: w_mem[k][r] = int8_t'($random(seed)) >>> 4;
          MODE_LARGE: w_mem[k][r] = (r < `SA_ROWS / 2) ? int8_t'(mag) : int8_t'(-mag);
          default:    w_mem[k][r] = int8_t'($random(seed));
        endcase
      end
      for (int c = 0; c < `SA_COLS; c++) begin
        mag = 64 + ({$random(seed)} % 64);
        case (mode)
          MODE_SMALL: a_mem[k][c] = int8_t'($random(seed)) >>> 4;
          MODE_LARGE: a_mem[k][c] = int8_t'(mag);
          default:    a_mem[k][c] = int8_t'($random(seed));
        endcase
      end
    end
  endtask

  // C[r][c] = sum_k w_k[r] * a_k[c] followed by shift and clamp
  task automatic compute_model(input int klen, input int shift);
    int sum;
    int scaled;
    for (int r = 0; r < `SA_ROWS; r++) begin
      for (int c = 0; c < `SA_COLS; c++) begin
        sum = 0;
        for (int k = 0; k < klen; k++) begin
          sum += int'(w_mem[k][r]) * int'(a_mem[k][c]);
        end
        scaled = sum >>> shift;
        if (scaled > 127) begin
          scaled = 127;
        end else if (scaled < -128) begin
          scaled = -128;
        end
        exp_rows[r][c] = int8_t'(scaled);
      end
    end
  endtask

  task automatic drive_junk();
    in_valid = 1'b1;
    for (int r = 0; r < `SA_ROWS; r++) begin
      w_vec[r] = int8_t'($random(seed));
    end
    for (int c = 0; c < `SA_COLS; c++) begin
      a_vec[c] = int8_t'($random(seed));
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // one full job with optional stray beats and a start in mid stream
  task automatic run_job(input string name, input int klen, input int shift,
                         input int mode, input int max_gap, input bit junk,
                         input bit busy_start);
    int errs_before;
    int rows_before;
    int gap;
    errs_before = err_cnt;
    cur_test    = name;
    gen_operands(mode, klen);
    while (busy) begin
      tick();
    end
    compute_model(klen, shift);
    rows_before = total_rows;
    if (junk) begin
      repeat (2) begin
        drive_junk();
        tick();
      end
    end
    start      = 1'b1;
    seen_start = 1'b1;
    job        = '{klen: klen_t'(klen), shift: shift_t'(shift)};
    in_valid   = junk;
    tick();
    start    = 1'b0;
    in_valid = 1'b0;
    for (int beat = 0; beat < klen; beat++) begin
      if (max_gap > 0) begin
        gap = {$random(seed)} % (max_gap + 1);
        repeat (gap) begin
          tick();
        end
      end
      in_valid = 1'b1;
      w_vec    = w_mem[beat];
      a_vec    = a_mem[beat];
      if (busy_start && beat == klen / 2) begin
        start = 1'b1;
        job   = '{klen: klen_t'(3), shift: shift_t'(7)};
      end
      tick();
      in_valid = 1'b0;
      start    = 1'b0;
    end
    // flush and drain with optional stray beats
    do begin
      if (junk) begin
        drive_junk();
      end else begin
        in_valid = 1'b0;
      end
      tick();
    end while (!done);
    in_valid = 1'b0;
    tick();
    a_row_count: assert (total_rows - rows_before == `SA_ROWS)
    else begin
      err_cnt++;
      $display("mismatch %s result count expected %0d actual %0d", name, `SA_ROWS,
               total_rows - rows_before);
    end
    report_test(name, errs_before);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int errs_before;
    clk      = 1'b0;
    rst_n    = 1'b0;
    start    = 1'b0;
    job      = '0;
    in_valid = 1'b0;
    w_vec    = '0;
    a_vec    = '0;
    repeat (RESET_CYC) begin
      tick();
    end
    rst_n = 1'b1;

    errs_before = err_cnt;
    cur_test    = "reset_idle";
    repeat (IDLE_CYC) begin
      tick();
    end
    report_test("reset_idle", errs_before);

    run_job("small_k5", 5, 0, MODE_SMALL, 0, 1'b0, 1'b0);
    run_job("large_sh0", 255, 0, MODE_LARGE, 0, 1'b0, 1'b0);
    run_job("large_sh16", 255, 16, MODE_LARGE, 0, 1'b0, 1'b0);
    run_job("large_sh23", 255, 23, MODE_LARGE, 0, 1'b0, 1'b0);
    run_job("gaps_and_junk", 20, 2, MODE_FULL, 3, 1'b1, 1'b0);

    errs_before = err_cnt;
    cur_test    = "zero_len";
    start       = 1'b1;
    job         = '{klen: klen_t'(0), shift: shift_t'(4)};
    tick();
    start = 1'b0;
    repeat (IDLE_CYC - 1) begin
      tick();
    end
    report_test("zero_len", errs_before);

    run_job("start_while_busy", 12, 3, MODE_FULL, 0, 1'b0, 1'b1);
    run_job("back_to_back", 12, 1, MODE_FULL, 0, 1'b0, 1'b0);

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // ends a run that never reaches its last done
  initial begin
    repeat (BUDGET_CYC) begin
      @(posedge clk);
    end
    $display("watchdog expired after %0d cycles in test %s", BUDGET_CYC, cur_test);
    $display(">>> FAIL");
    $finish;
  end

endmodule
